//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
LINTFLAGS = --lint-only --timing
TOP       = tb_display_adapter
FLIST     = flist.f
BUILD     = obj_dir
LOG       = sim.log
PASS_TEXT = STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- bench/display_checker.sv
`timescale 1ns/1ns

module display_checker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    ex_pulse,
    input  logic                    en,
    input  display_pkg::job_e       job,
    input  logic                    done,
    input  logic                    cmd_en,
    input  display_pkg::tft_op_e    cmd_op,
    input  display_pkg::coord_t     cmd_d1,
    input  display_pkg::coord_t     cmd_d2,
    input  display_pkg::coord_t     cmd_d3,
    input  display_pkg::coord_t     cmd_d4,
    input  logic                    cmd_done,
    input  display_pkg::font_addr_t font_addr,
    input  display_pkg::font_data_t rom [2 ** display_pkg::font_addr_w],
    output int                      error_count,
    output int                      job_count,
    output int                      job_fail_count,
    output int                      cmd_count
);

    localparam int cmds_per_digit = display_pkg::glyph_bytes + 2;   // Set, fills, end.
    localparam int job_cmds       = display_pkg::digit_count * cmds_per_digit;
    localparam int count_mod      = 100000000;                       // Eight decades.

    int   pulse_count;      // Model of the BCD counter.
    int   job_pulses;       // Count frozen at the first command.
    int   cmd_idx;          // Commands seen in this job.
    int   fin_idx;          // Commands answered in this job.
    int   job_errors;
    logic pulse_q;
    logic en_q;
    logic done_q;           // cmd_done in the previous cycle.
    logic expect_done;
    logic req_seen;
    logic early_flagged;

    display_pkg::tft_op_e held_op;
    display_pkg::coord_t  held_d1;
    display_pkg::coord_t  held_d2;
    display_pkg::coord_t  held_d3;
    display_pkg::coord_t  held_d4;

    function automatic int decade_of(int value, int k);
        int v;
        v = value;
        for (int i = 0; i < k; i++) begin
            v = v / 10;
        end
        return v % 10;
    endfunction

    task automatic compare_field(string name, logic [15:0] expected, logic [15:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] job %0d cmd %0d %s: expected %h, actual %h",
                     job_count, cmd_idx, name, expected, actual);
            error_count++;
            job_errors++;
        end
    endtask

    task automatic fail_plain(string what);
        $display("Job %0d: %s", job_count, what);
        error_count++;
        job_errors++;
    endtask

    ////////////////////////////////////////
    // Expected command at a cmd_en rise
    ////////////////////////////////////////
    task automatic check_command();
        int                      k;
        int                      j;
        int                      digit;
        int                      y_top;
        display_pkg::font_addr_t addr;
        if (cmd_idx == 0) begin
            job_pulses = pulse_count;                       // No pulses during a job.
        end
        if (cmd_idx >= job_cmds) begin
            fail_plain("command issued after the last area_end");
        end else begin
            k     = cmd_idx / cmds_per_digit;
            j     = cmd_idx % cmds_per_digit;
            digit = decade_of(job_pulses, k);
            y_top = display_pkg::counter_y + display_pkg::glyph_h * k;
            if (j == 0) begin                               // Glyph area.
                compare_field("cmd_op", 16'(display_pkg::op_area_set), 16'(cmd_op));
                compare_field("cmd_d1",
                    16'(display_pkg::counter_x - display_pkg::glyph_w + 1), cmd_d1);
                compare_field("cmd_d2", 16'(y_top), cmd_d2);
                compare_field("cmd_d3", 16'(display_pkg::counter_x), cmd_d3);
                compare_field("cmd_d4", 16'(y_top + display_pkg::glyph_h - 1), cmd_d4);
            end else if (j <= display_pkg::glyph_bytes) begin
                addr = display_pkg::font_addr_t'(display_pkg::glyph_base +
                       display_pkg::glyph_bytes * digit + j - 1);
                compare_field("cmd_op", 16'(display_pkg::op_area_fill), 16'(cmd_op));
                compare_field("font_addr", 16'(addr), 16'(font_addr));
                compare_field("cmd_d1", 16'(rom[addr]), cmd_d1);
                compare_field("cmd_d2", display_pkg::color_pink, cmd_d2);
            end else begin
                compare_field("cmd_op", 16'(display_pkg::op_area_end), 16'(cmd_op));
            end
        end
        held_op = cmd_op;                                   // Must hold until done.
        held_d1 = cmd_d1;
        held_d2 = cmd_d2;
        held_d3 = cmd_d3;
        held_d4 = cmd_d4;
        cmd_idx++;
        cmd_count++;
    endtask

    task automatic close_job();
        if (cmd_idx != job_cmds) begin
            $display("Job %0d: %0d commands issued instead of %0d", job_count, cmd_idx, job_cmds);
            error_count++;
            job_errors++;
        end
        if (job_errors == 0) begin
            $display("Job %0d: count %08d, %0d commands, ok", job_count, job_pulses, cmd_idx);
        end else begin
            $display("Job %0d: count %08d, %0d commands, %0d errors",
                     job_count, job_pulses, cmd_idx, job_errors);
            job_fail_count++;
        end
        job_count++;
        cmd_idx    = 0;
        fin_idx    = 0;
        job_errors = 0;
    endtask

    ////////////////////////////////////////
    // Sampled on every rising edge
    ////////////////////////////////////////
    always @(posedge clk) begin
        if (!rst_n) begin
            pulse_count    = 0;
            job_pulses     = 0;
            cmd_idx        = 0;
            fin_idx        = 0;
            job_errors     = 0;
            pulse_q        = 1'b0;
            en_q           = 1'b0;
            done_q         = 1'b0;
            expect_done    = 1'b0;
            req_seen       = 1'b0;
            early_flagged  = 1'b0;
            error_count    = 0;
            job_count      = 0;
            job_fail_count = 0;
            cmd_count      = 0;
        end else begin
            if (ex_pulse && !pulse_q) begin
                pulse_count = (pulse_count + 1) % count_mod;    // Wraps like the DUT.
            end
            pulse_q = ex_pulse;
            if (en && job == display_pkg::job_draw_counter) begin
                req_seen = 1'b1;
            end
            if (!req_seen && (cmd_en || done) && !early_flagged) begin
                fail_plain("cmd_en or done went high before any request");
                early_flagged = 1'b1;
            end
            // done must follow the last answered command by one clock.
            if (done && !expect_done) begin
                fail_plain("done pulsed when no job had just finished");
            end else if (!done && expect_done) begin
                fail_plain("done missing on the clock after the last cmd_done");
            end
            if (done) begin
                close_job();
            end
            expect_done = 1'b0;
            if (en_q && done_q && cmd_en) begin
                fail_plain("cmd_en still high on the clock after cmd_done");
            end else if (en_q && cmd_en) begin                  // Payload hold.
                compare_field("cmd_op held", 16'(held_op), 16'(cmd_op));
                compare_field("cmd_d1 held", held_d1, cmd_d1);
                compare_field("cmd_d2 held", held_d2, cmd_d2);
                compare_field("cmd_d3 held", held_d3, cmd_d3);
                compare_field("cmd_d4 held", held_d4, cmd_d4);
            end
            if (cmd_en && !en_q) begin
                check_command();
            end
            if (cmd_en && cmd_done) begin
                fin_idx++;
                if (fin_idx == job_cmds) begin
                    expect_done = 1'b1;
                end
            end
            en_q   = cmd_en;
            done_q = cmd_done;
        end
    end

endmodule

//--- bench/tb_display_adapter.sv
`timescale 1ns/1ns

module tb_display_adapter;

    ////////////////////////////////////////
    // Run length
    ////////////////////////////////////////
    localparam int rounds       = 6;
    localparam int max_pulses   = 300;      // Largest burst per round.
    localparam int pulse_cycles = 8;        // 4 high plus 4 low at most.
    localparam int job_cmds     = display_pkg::digit_count * (display_pkg::glyph_bytes + 2);
    localparam int cmd_cycles   = 12;       // Answer delay plus exchange overhead.
    localparam int cycle_limit  = rounds * (max_pulses * pulse_cycles + job_cmds * cmd_cycles)
                                  + 2000;
    localparam int rom_words    = 2 ** display_pkg::font_addr_w;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    en;
    display_pkg::job_e       job;
    logic                    ex_pulse;
    logic                    cmd_done = 1'b0;   // Driven by the responder.
    logic                    done;
    logic                    cmd_en;
    display_pkg::tft_op_e    cmd_op;
    display_pkg::coord_t     cmd_d1;
    display_pkg::coord_t     cmd_d2;
    display_pkg::coord_t     cmd_d3;
    display_pkg::coord_t     cmd_d4;
    display_pkg::font_addr_t font_addr;
    display_pkg::font_data_t font_data;
    display_pkg::font_data_t font_rom [rom_words];  // Shared with the checker.

    logic en_seen = 1'b0;                   // Last sampled cmd_en.
    int   delay_left = 0;                   // Cycles until cmd_done.
    int   cycle_count = 0;
    int   error_count;
    int   job_count;
    int   job_fail_count;
    int   cmd_count;

    always #10 clk = ~clk;                  // 20 ns period.

    display_adapter dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .job       (job),
        .ex_pulse  (ex_pulse),
        .done      (done),
        .cmd_en    (cmd_en),
        .cmd_op    (cmd_op),
        .cmd_d1    (cmd_d1),
        .cmd_d2    (cmd_d2),
        .cmd_d3    (cmd_d3),
        .cmd_d4    (cmd_d4),
        .font_addr (font_addr),
        .cmd_done  (cmd_done),
        .font_data (font_data)
    );

    display_checker u_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .ex_pulse       (ex_pulse),
        .en             (en),
        .job            (job),
        .done           (done),
        .cmd_en         (cmd_en),
        .cmd_op         (cmd_op),
        .cmd_d1         (cmd_d1),
        .cmd_d2         (cmd_d2),
        .cmd_d3         (cmd_d3),
        .cmd_d4         (cmd_d4),
        .cmd_done       (cmd_done),
        .font_addr      (font_addr),
        .rom            (font_rom),
        .error_count    (error_count),
        .job_count      (job_count),
        .job_fail_count (job_fail_count),
        .cmd_count      (cmd_count)
    );

    assign font_data = font_rom[font_addr];   // Asynchronous ROM.

    ////////////////////////////////////////
    // TFT controller responder
    ////////////////////////////////////////
    always @(posedge clk) begin
        int delay;
        if (!rst_n) begin
            cmd_done   <= 1'b0;
            en_seen    <= 1'b0;
            delay_left <= 0;
        end else begin
            en_seen  <= cmd_en;
            cmd_done <= 1'b0;                       // One-cycle answer.
            if (cmd_en && !en_seen) begin           // New command seen.
                delay = $urandom_range(8, 1);
                if (delay == 1) begin
                    cmd_done <= 1'b1;
                end else begin
                    delay_left <= delay - 1;
                end
            end else if (delay_left > 0) begin
                delay_left <= delay_left - 1;
                if (delay_left == 1) begin
                    cmd_done <= 1'b1;
                end
            end
        end
    end

    // Watchdog.
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic send_pulse();
        int high_cycles;
        int low_cycles;
        high_cycles = $urandom_range(4, 2);
        low_cycles  = $urandom_range(4, 2);
        ex_pulse <= 1'b1;
        repeat (high_cycles) @(posedge clk);
        ex_pulse <= 1'b0;
        repeat (low_cycles) @(posedge clk);
    endtask

    // Request held until done, then dropped so the job does not restart.
    task automatic request_draw();
        en  <= 1'b1;
        job <= display_pkg::job_draw_counter;
        do @(posedge clk); while (!done);
        en  <= 1'b0;
        job <= display_pkg::job_idle;
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    initial begin
        int burst;
        void'($urandom(14479));
        for (int a = 0; a < rom_words; a++) begin
            font_rom[display_pkg::font_addr_t'(a)] = display_pkg::font_data_t'($urandom);
        end
        rst_n    = 1'b0;
        en       = 1'b0;
        job      = display_pkg::job_idle;
        ex_pulse = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (5) @(posedge clk);                  // Quiet time after reset.
        for (int r = 0; r < rounds; r++) begin
            burst = $urandom_range(max_pulses, 0);
            for (int p = 0; p < burst; p++) begin
                send_pulse();
            end
            repeat (6) @(posedge clk);              // Counter settles.
            request_draw();
        end
        repeat (5) @(posedge clk);
        if (job_count != rounds) begin
            $display("Only %0d of %0d jobs completed", job_count, rounds);
        end
        $display("Totals: %0d jobs, %0d failed, %0d commands, %0d errors",
                 job_count, job_fail_count, cmd_count, error_count);
        if (error_count == 0 && job_count == rounds) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- flist.f
src/display_pkg.sv
src/pulse_counter.sv
src/cmd_port.sv
src/digit_painter.sv
src/display_adapter.sv
bench/display_checker.sv
bench/tb_display_adapter.sv

//--- src/cmd_port.sv
`timescale 1ns/1ns

module cmd_port (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    issue,      // One-cycle request.
    input  display_pkg::tft_op_e    op,
    input  display_pkg::coord_t     d1,
    input  display_pkg::coord_t     d2,
    input  display_pkg::coord_t     d3,
    input  display_pkg::coord_t     d4,
    output logic                    busy,
    output logic                    finished,
    output logic                    cmd_en,
    output display_pkg::tft_op_e    cmd_op,
    output display_pkg::coord_t     cmd_d1,
    output display_pkg::coord_t     cmd_d2,
    output display_pkg::coord_t     cmd_d3,
    output display_pkg::coord_t     cmd_d4,
    input  logic                    cmd_done    // One-cycle answer.
);

    ////////////////////////////////////////
    // Enable held until the controller answers
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_en <= 1'b0;
        end else if (cmd_en && cmd_done) begin
            cmd_en <= 1'b0;                 // Falls on the clock after done.
        end else if (issue && !busy) begin
            cmd_en <= 1'b1;                 // Rises on the clock after issue.
        end
    end

    // Command payload, frozen while enable is high.
    always_ff @(posedge clk) begin
        if (issue && !busy) begin
            cmd_op <= op;
            cmd_d1 <= d1;
            cmd_d2 <= d2;
            cmd_d3 <= d3;
            cmd_d4 <= d4;
        end
    end

    // Busy covers the done cycle too, so the earliest next issue lands
    // in the first low cycle of cmd_en and leaves one idle cycle.
    assign busy     = cmd_en;
    assign finished = cmd_en & cmd_done;    // Same cycle as cmd_done.

endmodule

//--- src/digit_painter.sv
`timescale 1ns/1ns

module digit_painter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        en,
    input  display_pkg::job_e           job,
    input  display_pkg::bcd_t           digit,      // Live decade value.
    output display_pkg::digit_sel_t     digit_sel,
    output display_pkg::font_addr_t     font_addr,
    input  display_pkg::font_data_t     font_data,  // Async ROM byte.
    input  logic                        busy,
    input  logic                        finished,
    output logic                        issue,
    output display_pkg::tft_op_e        op,
    output display_pkg::coord_t         d1,
    output display_pkg::coord_t         d2,
    output display_pkg::coord_t         d3,
    output display_pkg::coord_t         d4,
    output logic                        done
);

    display_pkg::paint_state_e state;
    display_pkg::digit_sel_t   digit_idx;       // Decade being drawn.
    display_pkg::coord_t       y_pos;           // Top y of current glyph.
    logic [5:0]                byte_cnt;        // Fill bytes sent.
    logic                      cmd_state;       // State that sends a command.
    logic                      last_byte;
    logic                      last_digit;

    assign digit_sel  = digit_idx;
    assign last_byte  = (byte_cnt == 6'(display_pkg::glyph_bytes - 1));
    assign last_digit = (digit_idx == display_pkg::digit_sel_t'(display_pkg::digit_count - 1));

    ////////////////////////////////////////
    // Command request
    ////////////////////////////////////////
    assign cmd_state = (state == display_pkg::st_set) || (state == display_pkg::st_fill) ||
                       (state == display_pkg::st_end);
    assign issue     = cmd_state && !busy;

    always_comb begin
        op = display_pkg::op_area_end;  // Unused data words stay zero.
        d1 = '0;
        d2 = '0;
        d3 = '0;
        d4 = '0;
        case (state)
            display_pkg::st_set: begin
                op = display_pkg::op_area_set;
                d1 = display_pkg::coord_t'(display_pkg::counter_x - display_pkg::glyph_w + 1);
                d2 = y_pos;
                d3 = display_pkg::coord_t'(display_pkg::counter_x);
                d4 = y_pos + display_pkg::coord_t'(display_pkg::glyph_h - 1);
            end
            display_pkg::st_fill: begin
                op = display_pkg::op_area_fill;
                d1 = display_pkg::coord_t'(font_data);      // Zero-extended byte.
                d2 = display_pkg::color_pink;
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////
    // Job FSM
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= display_pkg::st_idle;
            digit_idx <= '0;
            y_pos     <= '0;
            byte_cnt  <= '0;
            font_addr <= '0;
            done      <= 1'b0;
        end else begin
            case (state)
                display_pkg::st_idle: begin
                    done <= 1'b0;
                    if (en && job == display_pkg::job_draw_counter) begin
                        digit_idx <= '0;
                        y_pos     <= display_pkg::coord_t'(display_pkg::counter_y);
                        state     <= display_pkg::st_pick;
                    end
                end
                display_pkg::st_pick: begin                 // Digit sampled here.
                    font_addr <= display_pkg::font_addr_t'(display_pkg::glyph_base +
                                 display_pkg::glyph_bytes * digit);
                    byte_cnt  <= '0;
                    state     <= display_pkg::st_set;
                end
                display_pkg::st_set: begin
                    if (finished) state <= display_pkg::st_fill;
                end
                display_pkg::st_fill: begin
                    if (finished) begin
                        font_addr <= font_addr + 1'b1;      // Next glyph byte.
                        byte_cnt  <= byte_cnt + 6'd1;
                        if (last_byte) state <= display_pkg::st_end;
                    end
                end
                display_pkg::st_end: begin
                    if (finished) begin
                        if (last_digit) begin
                            done  <= 1'b1;                  // Clock after last done.
                            state <= display_pkg::st_finish;
                        end else begin
                            state <= display_pkg::st_next;
                        end
                    end
                end
                display_pkg::st_next: begin
                    digit_idx <= digit_idx + 3'd1;
                    y_pos     <= y_pos + display_pkg::coord_t'(display_pkg::glyph_h);
                    state     <= display_pkg::st_pick;
                end
                display_pkg::st_finish: begin
                    done  <= 1'b0;                          // One-cycle pulse.
                    state <= display_pkg::st_idle;
                end
                default: state <= display_pkg::st_idle;
            endcase
        end
    end

endmodule

//--- src/display_adapter.sv
`timescale 1ns/1ns

module display_adapter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        en,
    input  display_pkg::job_e           job,
    input  logic                        ex_pulse,   // Photon pulse pin.
    output logic                        done,
    output logic                        cmd_en,     // To the TFT controller.
    output display_pkg::tft_op_e        cmd_op,
    output display_pkg::coord_t         cmd_d1,
    output display_pkg::coord_t         cmd_d2,
    output display_pkg::coord_t         cmd_d3,
    output display_pkg::coord_t         cmd_d4,
    output display_pkg::font_addr_t     font_addr,  // To the font ROM.
    input  logic                        cmd_done,
    input  display_pkg::font_data_t     font_data
);

    display_pkg::digit_sel_t digit_sel;
    display_pkg::bcd_t       digit;
    logic                    busy;
    logic                    finished;
    logic                    issue;
    display_pkg::tft_op_e    op;
    display_pkg::coord_t     d1;
    display_pkg::coord_t     d2;
    display_pkg::coord_t     d3;
    display_pkg::coord_t     d4;

    pulse_counter u_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_pulse  (ex_pulse),
        .digit_sel (digit_sel),
        .digit     (digit)
    );

    digit_painter u_painter (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .job       (job),
        .digit     (digit),
        .digit_sel (digit_sel),
        .font_addr (font_addr),
        .font_data (font_data),
        .busy      (busy),
        .finished  (finished),
        .issue     (issue),
        .op        (op),
        .d1        (d1),
        .d2        (d2),
        .d3        (d3),
        .d4        (d4),
        .done      (done)
    );

    cmd_port u_cmd (
        .clk       (clk),
        .rst_n     (rst_n),
        .issue     (issue),
        .op        (op),
        .d1        (d1),
        .d2        (d2),
        .d3        (d3),
        .d4        (d4),
        .busy      (busy),
        .finished  (finished),
        .cmd_en    (cmd_en),
        .cmd_op    (cmd_op),
        .cmd_d1    (cmd_d1),
        .cmd_d2    (cmd_d2),
        .cmd_d3    (cmd_d3),
        .cmd_d4    (cmd_d4),
        .cmd_done  (cmd_done)
    );

endmodule

//--- src/display_pkg.sv
package display_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////
    localparam int coord_w     = 16;        // Command data word.
    localparam int font_addr_w = 11;        // 2K font ROM.
    localparam int font_data_w = 8;         // One byte per ROM word.
    localparam int digit_count = 8;         // BCD decades on screen.

    typedef logic [coord_w-1:0]     coord_t;
    typedef logic [font_addr_w-1:0] font_addr_t;
    typedef logic [font_data_w-1:0] font_data_t;
    typedef logic [3:0]             bcd_t;       // One decade.
    typedef logic [2:0]             digit_sel_t; // Decade index.

    ////////////////////////////////////////
    // Glyph layout and placement
    ////////////////////////////////////////
    localparam int glyph_base  = 1024;      // Glyph "0" in the font ROM.
    localparam int glyph_bytes = 36;        // 12 x 24 bits.
    localparam int glyph_w     = 24;        // Along screen x.
    localparam int glyph_h     = 12;        // Along screen y.
    localparam int counter_x   = 229;       // Right edge of the digit row.
    localparam int counter_y   = 680;       // Least significant digit.

    localparam coord_t color_pink = 16'hF81F; // RGB565.

    // Controller opcodes used by this design.
    typedef enum logic [3:0] {
        op_area_set  = 4'd6,                // x1, y1, x2, y2.
        op_area_fill = 4'd7,                // Font byte, color.
        op_area_end  = 4'd8
    } tft_op_e;

    typedef enum logic [2:0] {
        st_idle, st_pick, st_set, st_fill, st_end, st_next, st_finish
    } paint_state_e;

    // Request codes, same numbering as the adapter trigger.
    typedef enum logic [3:0] {
        job_idle         = 4'd0,
        job_draw_counter = 4'd4
    } job_e;

endpackage

//--- src/pulse_counter.sv
`timescale 1ns/1ns

module pulse_counter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    ex_pulse,   // Asynchronous photon pulse.
    input  display_pkg::digit_sel_t digit_sel,
    output display_pkg::bcd_t       digit
);

    logic                     sync1;                                // First sync stage.
    logic                     sync2;                                // Second sync stage.
    logic                     pulse_q;                              // Edge register.
    logic                     rise;
    logic [display_pkg::digit_count-1:0] carry;                     // Ripple carry in.
    display_pkg::bcd_t        decade [display_pkg::digit_count];    // Index 0 is the LSD.

    ////////////////////////////////////////
    // Synchronizer and edge detect
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync1   <= 1'b0;
            sync2   <= 1'b0;
            pulse_q <= 1'b0;
        end else begin
            sync1   <= ex_pulse;
            sync2   <= sync1;
            pulse_q <= sync2;
        end
    end

    assign rise = sync2 & ~pulse_q;                                 // One cycle per edge.

    ////////////////////////////////////////
    // BCD decades
    ////////////////////////////////////////
    always_comb begin
        carry[0] = rise;
        for (int k = 1; k < display_pkg::digit_count; k++) begin
            carry[k] = carry[k-1] && (decade[k-1] == 4'd9);         // Lower decade rolls.
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < display_pkg::digit_count; k++) begin
                decade[k] <= 4'd0;
            end
        end else begin
            // Top decade simply wraps, so 99999999 goes back to zero.
            for (int k = 0; k < display_pkg::digit_count; k++) begin
                if (carry[k]) begin
                    decade[k] <= (decade[k] == 4'd9) ? 4'd0 : decade[k] + 4'd1;
                end
            end
        end
    end

    assign digit = decade[digit_sel];                               // Painter read port.

endmodule
